// ==== rtl/conv_geom_pkg.sv ====
package conv_geom_pkg;

  // pixel and coefficient width.
  localparam int PIX_W   = 6;
  localparam int K_SIZE  = 5;
  localparam int K_TAPS  = K_SIZE * K_SIZE;
  localparam int IMG_W   = 12;
  localparam int IMG_H   = 8;
  // holds 25 * 63 * 63.
  localparam int SUM_W   = 18;
  localparam int N_LANES = 4;

  // output grid of fully covered windows.
  localparam int OUT_W  = IMG_W - K_SIZE + 1;
  localparam int OUT_H  = IMG_H - K_SIZE + 1;
  localparam int OCOL_W = $clog2(OUT_W);
  localparam int OROW_W = $clog2(OUT_H);

  typedef logic [PIX_W-1:0] pixel_t;
  typedef logic [SUM_W-1:0] sum_t;

  // tap 0 is oldest row, leftmost column; row-major.
  typedef pixel_t [K_TAPS-1:0] window_t;

  typedef struct packed {
    logic [OROW_W-1:0] row;
    logic [OCOL_W-1:0] col;
    logic              last_in_frame;
  } win_tag_t;

endpackage

// ==== rtl/conv_stream_pkg.sv ====
package conv_stream_pkg;

  typedef enum logic {
    KIND_PIXEL = 1'b0,
    KIND_LOAD  = 1'b1
  } beat_kind_e;

  // coefficient write into one lane's kernel.
  typedef struct packed {
    logic [1:0]            lane;
    logic [4:0]            tap;
    conv_geom_pkg::pixel_t coeff;
  } load_cmd_t;

  typedef struct packed {
    logic [6:0]            pad;
    conv_geom_pkg::pixel_t pixel;
  } pixel_cmd_t;

  // same 13 bits, read by kind.
  typedef union packed {
    load_cmd_t  load;
    pixel_cmd_t pix;
  } in_payload_u;

  typedef struct packed {
    beat_kind_e  kind;
    in_payload_u payload;
  } in_beat_t;

  typedef struct packed {
    conv_geom_pkg::sum_t     sum;
    conv_geom_pkg::win_tag_t tag;
  } lane_out_t;

  // sums indexed by lane.
  typedef struct packed {
    conv_geom_pkg::win_tag_t                             tag;
    conv_geom_pkg::sum_t [conv_geom_pkg::N_LANES-1:0]    sums;
  } out_beat_t;

endpackage

// ==== rtl/conv_window_feeder.sv ====
`timescale 1ns/100ps

module conv_window_feeder (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  conv_stream_pkg::in_beat_t  in_beat,
  input  logic                       advance,
  output logic                       load_valid,
  output conv_stream_pkg::load_cmd_t load_cmd,
  output logic                       win_valid,
  output conv_geom_pkg::window_t     win,
  output conv_geom_pkg::win_tag_t    win_tag
);

  import conv_geom_pkg::*;
  import conv_stream_pkg::*;

  localparam int COL_W = $clog2(IMG_W);
  localparam int ROW_W = $clog2(IMG_H);

  logic [COL_W-1:0] col_cnt;
  logic [ROW_W-1:0] row_cnt;
  logic             accept;
  logic             pix_accept;
  logic             completes;
  pixel_t           pixel;
  pixel_t           new_col [K_SIZE];
  pixel_t           line_buf [K_SIZE-1][IMG_W];
  win_tag_t         tag_d;

  // window register frees up when the lanes take it.
  assign in_ready   = !win_valid || advance;
  assign accept     = in_valid && in_ready;
  assign pix_accept = accept && (in_beat.kind == KIND_PIXEL);

  // loads go straight to the lanes.
  assign load_valid = accept && (in_beat.kind == KIND_LOAD);
  assign load_cmd   = in_beat.payload.load;
  assign pixel      = in_beat.payload.pix.pixel;

  assign completes = (col_cnt >= COL_W'(K_SIZE - 1)) && (row_cnt >= ROW_W'(K_SIZE - 1));

  // column entering the window, oldest row on top.
  always_comb begin
    for (int k = 0; k < K_SIZE - 1; k++) begin
      new_col[k] = line_buf[k][col_cnt];
    end
    new_col[K_SIZE-1] = pixel;
  end

  always_comb begin
    tag_d.row           = OROW_W'(row_cnt - ROW_W'(K_SIZE - 1));
    tag_d.col           = OCOL_W'(col_cnt - COL_W'(K_SIZE - 1));
    tag_d.last_in_frame = (row_cnt == ROW_W'(IMG_H - 1)) && (col_cnt == COL_W'(IMG_W - 1));
  end

  // line buffers shift up one row per column slot.
  always_ff @(posedge clk) begin
    if (pix_accept) begin
      for (int k = 0; k < K_SIZE - 2; k++) begin
        line_buf[k][col_cnt] <= line_buf[k+1][col_cnt];
      end
      line_buf[K_SIZE-2][col_cnt] <= pixel;
    end
  end

  always_ff @(posedge clk) begin
    if (pix_accept) begin
      for (int r = 0; r < K_SIZE; r++) begin
        for (int c = 0; c < K_SIZE - 1; c++) begin
          win[r*K_SIZE + c] <= win[r*K_SIZE + c + 1];
        end
        win[r*K_SIZE + K_SIZE - 1] <= new_col[r];
      end
      win_tag <= tag_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      col_cnt   <= '0;
      row_cnt   <= '0;
      win_valid <= 1'b0;
    end else begin
      if (pix_accept) begin
        if (col_cnt == COL_W'(IMG_W - 1)) begin
          col_cnt <= '0;
          row_cnt <= (row_cnt == ROW_W'(IMG_H - 1)) ? '0 : row_cnt + 1'b1;
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
      if (pix_accept && completes) begin
        win_valid <= 1'b1;
      end else if (advance) begin
        win_valid <= 1'b0;
      end
    end
  end

  // a pending window waits for the lanes untouched.
  a_win_hold : assert property (
    @(posedge clk) disable iff (rst)
    win_valid && !advance |=> win_valid && $stable(win) && $stable(win_tag)
  );

endmodule

// ==== rtl/conv_mac_lane.sv ====
`timescale 1ns/100ps

module conv_mac_lane (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [1:0]                 lane_id,
  input  logic                       load_valid,
  input  conv_stream_pkg::load_cmd_t load_cmd,
  input  logic                       advance,
  input  logic                       win_valid,
  input  conv_geom_pkg::window_t     win,
  input  conv_geom_pkg::win_tag_t    win_tag,
  output logic                       lane_valid,
  output conv_stream_pkg::lane_out_t lane_out
);

  import conv_geom_pkg::*;

  localparam int PROD_W = 2 * PIX_W;
  localparam int TREE_N = 1 << $clog2(K_TAPS);

  pixel_t            kernel [K_TAPS];
  logic [PROD_W-1:0] prod [K_TAPS];
  logic              prod_valid;
  win_tag_t          prod_tag;
  sum_t              node [2*TREE_N-1];

  // kernel register file.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < K_TAPS; t++) begin
        kernel[t] <= '0;
      end
    end else if (load_valid && (load_cmd.lane == lane_id)) begin
      kernel[load_cmd.tap] <= load_cmd.coeff;
    end
  end

  // product registers.
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int t = 0; t < K_TAPS; t++) begin
        prod[t] <= PROD_W'(win[t]) * PROD_W'(kernel[t]);
      end
      prod_tag <= win_tag;
    end
  end

  // heap-ordered tree with leaves padded to a power of two.
  always_comb begin
    for (int i = 0; i < TREE_N; i++) begin
      node[TREE_N-1+i] = '0;
    end
    for (int t = 0; t < K_TAPS; t++) begin
      node[TREE_N-1+t] = SUM_W'(prod[t]);
    end
    for (int i = TREE_N - 2; i >= 0; i--) begin
      node[i] = node[2*i+1] + node[2*i+2];
    end
  end

  // sum register.
  always_ff @(posedge clk) begin
    if (advance) begin
      lane_out.sum <= node[0];
      lane_out.tag <= prod_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prod_valid <= 1'b0;
      lane_valid <= 1'b0;
    end else if (advance) begin
      prod_valid <= win_valid;
      lane_valid <= prod_valid;
    end
  end

  // the feeder passes loads through unchecked.
  a_tap_range : assert property (
    @(posedge clk) disable iff (rst)
    load_valid |-> (load_cmd.tap < 5'(K_TAPS))
  );

endmodule

// ==== rtl/conv_result_packer.sv ====
`timescale 1ns/100ps

module conv_result_packer (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  logic [conv_geom_pkg::N_LANES-1:0]                      lane_valid,
  input  conv_stream_pkg::lane_out_t [conv_geom_pkg::N_LANES-1:0] lane_out,
  output logic                                                   advance,
  output logic                                                   out_valid,
  input  logic                                                   out_ready,
  output conv_stream_pkg::out_beat_t                             out_beat
);

  import conv_geom_pkg::*;

  // whole pipeline moves when the output slot is free.
  assign advance = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= lane_valid[0];
    end
  end

  // lanes share one tag.
  always_ff @(posedge clk) begin
    if (advance) begin
      out_beat.tag <= lane_out[0].tag;
      for (int i = 0; i < N_LANES; i++) begin
        out_beat.sums[i] <= lane_out[i].sum;
      end
    end
  end

  a_lockstep : assert property (
    @(posedge clk) disable iff (rst)
    (&lane_valid) || !(|lane_valid)
  );

  a_out_hold : assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat)
  );

endmodule

// ==== rtl/conv5x5_engine.sv ====
`timescale 1ns/100ps

module conv5x5_engine (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  conv_stream_pkg::in_beat_t  in_beat,
  output logic                       out_valid,
  input  logic                       out_ready,
  output conv_stream_pkg::out_beat_t out_beat
);

  import conv_geom_pkg::*;
  import conv_stream_pkg::*;

  logic                      load_valid;
  load_cmd_t                 load_cmd;
  logic                      advance;
  logic                      win_valid;
  window_t                   win;
  win_tag_t                  win_tag;
  logic [N_LANES-1:0]        lane_valid;
  lane_out_t [N_LANES-1:0]   lane_out;

  conv_window_feeder u_feeder (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_beat    (in_beat),
    .advance    (advance),
    .load_valid (load_valid),
    .load_cmd   (load_cmd),
    .win_valid  (win_valid),
    .win        (win),
    .win_tag    (win_tag)
  );

  // one kernel per lane, same window.
  for (genvar i = 0; i < N_LANES; i++) begin : g_lane
    conv_mac_lane u_lane (
      .clk        (clk),
      .rst        (rst),
      .lane_id    (2'(i)),
      .load_valid (load_valid),
      .load_cmd   (load_cmd),
      .advance    (advance),
      .win_valid  (win_valid),
      .win        (win),
      .win_tag    (win_tag),
      .lane_valid (lane_valid[i]),
      .lane_out   (lane_out[i])
    );
  end

  conv_result_packer u_packer (
    .clk        (clk),
    .rst        (rst),
    .lane_valid (lane_valid),
    .lane_out   (lane_out),
    .advance    (advance),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_beat   (out_beat)
  );

endmodule

// ==== verification/conv_checker.sv ====
`timescale 1ns/100ps

module conv_checker (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       in_valid,
  input  logic                       in_ready,
  input  conv_stream_pkg::in_beat_t  in_beat,
  input  logic                       out_valid,
  input  logic                       out_ready,
  input  conv_stream_pkg::out_beat_t out_beat,
  input  logic [8*16-1:0]            test_name,
  output logic                       drained,
  output int                         mismatches,
  output int                         proto_errors,
  output int                         outputs_seen
);

  import conv_geom_pkg::*;
  import conv_stream_pkg::*;

  int        img [IMG_H][IMG_W];
  int        kern [N_LANES][K_TAPS];
  int        pix_count;
  int        frame_outs;
  out_beat_t exp_q [$];

  // expected beat for the window with its top-left pixel at (orow, ocol).
  function automatic out_beat_t expect_window(int orow, int ocol);
    out_beat_t e;
    int        acc;
    e.tag.row           = OROW_W'(orow);
    e.tag.col           = OCOL_W'(ocol);
    e.tag.last_in_frame = (orow == OUT_H - 1) && (ocol == OUT_W - 1);
    for (int l = 0; l < N_LANES; l++) begin
      acc = 0;
      for (int r = 0; r < K_SIZE; r++) begin
        for (int c = 0; c < K_SIZE; c++) begin
          acc += img[orow + r][ocol + c] * kern[l][r * K_SIZE + c];
        end
      end
      e.sums[l] = SUM_W'(acc);
    end
    return e;
  endfunction

  always @(posedge clk) begin : monitor
    out_beat_t e;
    int        row;
    int        col;
    if (rst) begin
      pix_count  = 0;
      frame_outs = 0;
      exp_q.delete();
    end else begin
      // outputs are always older than the pixel taken on the same edge.
      if (out_valid && out_ready) begin
        outputs_seen++;
        frame_outs++;
        if (exp_q.size() == 0) begin
          proto_errors++;
          $display("%0s: an output beat arrived while no window was pending", test_name);
        end else begin
          e = exp_q.pop_front();
          if (out_beat.tag !== e.tag) begin
            mismatches++;
            $display("[ERROR] %0s: tag expected row/col/last %0d/%0d/%0d, actual %0d/%0d/%0d",
                     test_name, e.tag.row, e.tag.col, e.tag.last_in_frame,
                     out_beat.tag.row, out_beat.tag.col, out_beat.tag.last_in_frame);
          end
          for (int l = 0; l < N_LANES; l++) begin
            if (out_beat.sums[l] !== e.sums[l]) begin
              mismatches++;
              $display("[ERROR] %0s: lane %0d sum expected %0d, actual %0d",
                       test_name, l, e.sums[l], out_beat.sums[l]);
            end
          end
        end
        if (out_beat.tag.last_in_frame) begin
          if (frame_outs != OUT_W * OUT_H) begin
            proto_errors++;
            $display("%0s: frame closed after %0d outputs instead of %0d",
                     test_name, frame_outs, OUT_W * OUT_H);
          end
          frame_outs = 0;
        end
      end
      if (in_valid && in_ready) begin
        if (in_beat.kind == KIND_LOAD) begin
          kern[in_beat.payload.load.lane][in_beat.payload.load.tap] = in_beat.payload.load.coeff;
        end else begin
          row = pix_count / IMG_W;
          col = pix_count % IMG_W;
          img[row][col] = in_beat.payload.pix.pixel;
          if ((row >= K_SIZE - 1) && (col >= K_SIZE - 1)) begin
            exp_q.push_back(expect_window(row - (K_SIZE - 1), col - (K_SIZE - 1)));
          end
          pix_count = (pix_count == IMG_W * IMG_H - 1) ? 0 : pix_count + 1;
        end
      end
    end
    drained = (pix_count == 0) && (exp_q.size() == 0);
  end

endmodule

// ==== verification/conv_tb.sv ====
`timescale 1ns/100ps

module conv_tb;

  import conv_geom_pkg::*;
  import conv_stream_pkg::*;

  localparam int N_TESTS    = 7;
  localparam int TEST_BEATS = N_LANES * K_TAPS + IMG_W * IMG_H;
  localparam int MAX_CYCLES = N_TESTS * TEST_BEATS * 8 + 200;

  // kernel and pixel pattern ids select the fill rules below.
  typedef struct packed {
    logic [8*16-1:0] name;
    logic [1:0]      kern_id;
    logic [1:0]      pix_id;
    logic [6:0]      gap_pct;
    logic [6:0]      ready_pct;
  } test_t;

  logic            clk;
  logic            rst;
  logic            in_valid;
  logic            in_ready;
  in_beat_t        in_beat;
  logic            out_valid;
  logic            out_ready;
  out_beat_t       out_beat;
  logic            drained;
  int              mismatches;
  int              proto_errors;
  int              outputs_seen;
  logic [8*16-1:0] cur_name;
  int              ready_pct;
  int              cycles = 0;
  integer          seed = 32'h90b0;
  integer          bp_seed;
  test_t           tests [N_TESTS];

  conv5x5_engine DUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  conv_checker scoreboard (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_beat      (in_beat),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_beat     (out_beat),
    .test_name    (cur_name),
    .drained      (drained),
    .mismatches   (mismatches),
    .proto_errors (proto_errors),
    .outputs_seen (outputs_seen)
  );

  always #10 clk = ~clk;

  function automatic int to_percent(int r);
    return (r & 32'h7fffffff) % 100;
  endfunction

  // back-pressure has its own random stream.
  always @(posedge clk) begin
    if (rst) begin
      out_ready <= 1'b0;
    end else begin
      out_ready <= (to_percent($random(bp_seed)) < ready_pct);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run passed %0d cycles during test %0s", MAX_CYCLES, cur_name);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic fill_table();
    tests[0] = '{"identity",     2'd0, 2'd0, 7'd0,  7'd100};
    tests[1] = '{"full_scale",   2'd1, 2'd1, 7'd0,  7'd100};
    tests[2] = '{"random_lanes", 2'd2, 2'd2, 7'd0,  7'd100};
    tests[3] = '{"fixed_free",   2'd3, 2'd3, 7'd0,  7'd100};
    tests[4] = '{"fixed_stall",  2'd3, 2'd3, 7'd30, 7'd50};
    tests[5] = '{"random_stall", 2'd2, 2'd2, 7'd25, 7'd40};
    tests[6] = '{"reload",       2'd0, 2'd3, 7'd10, 7'd70};
  endtask

  // identity at the centre tap of lane 0, all ones, random, or a fixed hash.
  function automatic pixel_t coeff_for(int kid, int lane, int tap);
    case (kid)
      0: return ((lane == 0) && (tap == K_TAPS / 2)) ? 6'd1 : 6'd0;
      1: return 6'd1;
      2: return pixel_t'($random(seed));
      default: return pixel_t'((lane * K_TAPS + tap) * 7 + 3);
    endcase
  endfunction

  function automatic pixel_t pixel_for(int pid, int row, int col);
    case (pid)
      0: return pixel_t'(row * IMG_W + col);
      1: return 6'd63;
      2: return pixel_t'($random(seed));
      default: return pixel_t'((row * IMG_W + col) * 37 + 11);
    endcase
  endfunction

  // entered just after a rising edge, returns on the edge that took the beat.
  task automatic send_beat(input in_beat_t beat, input int gap_pct);
    logic taken;
    while (to_percent($random(seed)) < gap_pct) begin
      in_valid <= 1'b0;
      @(posedge clk);
    end
    in_valid <= 1'b1;
    in_beat  <= beat;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
    end
  endtask

  task automatic run_test(input test_t t);
    in_beat_t b;
    cur_name  <= t.name;
    ready_pct <= t.ready_pct;
    for (int l = 0; l < N_LANES; l++) begin
      for (int tap = 0; tap < K_TAPS; tap++) begin
        b.kind               = KIND_LOAD;
        b.payload.load.lane  = 2'(l);
        b.payload.load.tap   = 5'(tap);
        b.payload.load.coeff = coeff_for(t.kern_id, l, tap);
        send_beat(b, t.gap_pct);
      end
    end
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        b.kind              = KIND_PIXEL;
        b.payload.pix.pad   = '0;
        b.payload.pix.pixel = pixel_for(t.pix_id, r, c);
        send_beat(b, t.gap_pct);
      end
    end
    in_valid <= 1'b0;
    do begin
      @(negedge clk);
    end while (!drained);
    @(posedge clk);
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b0;
    cur_name  = '0;
    ready_pct = 100;
    bp_seed   = ~seed;
    fill_table();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < N_TESTS; i++) begin
      run_test(tests[i]);
    end
    $display("checks done: %0d outputs, %0d value mismatches, %0d protocol errors",
             outputs_seen, mismatches, proto_errors);
    if ((mismatches == 0) && (proto_errors == 0) && (outputs_seen == N_TESTS * OUT_W * OUT_H)) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
rtl/conv_geom_pkg.sv
rtl/conv_stream_pkg.sv
rtl/conv_window_feeder.sv
rtl/conv_mac_lane.sv
rtl/conv_result_packer.sv
rtl/conv5x5_engine.sv
verification/conv_checker.sv
verification/conv_tb.sv

// ==== Bender.yml ====
package:
  name: conv5x5_engine

sources:
  # packages first, then the blocks, then the top level.
  - target: rtl
    files:
      - rtl/conv_geom_pkg.sv
      - rtl/conv_stream_pkg.sv
      - rtl/conv_window_feeder.sv
      - rtl/conv_mac_lane.sv
      - rtl/conv_result_packer.sv
      - rtl/conv5x5_engine.sv

  - target: test
    files:
      - verification/conv_checker.sv
      - verification/conv_tb.sv
